//--- fxp_defs.svh
`ifndef FXP_DEFS_SVH
`define FXP_DEFS_SVH

// input sample, signed Q4.12
`define FXP_IN_WIDTH    16
`define FXP_IN_POINT    12

// programmable gain, signed Q2.14
`define FXP_GAIN_WIDTH  16
`define FXP_GAIN_POINT  14

// full product, Q6.26 (widths and points both add up)
`define FXP_PROD_WIDTH  32
`define FXP_PROD_POINT  26

// output format, signed Q4.8
`define FXP_OUT_WIDTH   12
`define FXP_OUT_POINT   8

// result queue entries
`define FXP_FIFO_DEPTH  8

// gain after reset, 1.0 in Q2.14
`define FXP_GAIN_RESET  16'h4000

`endif

//--- fxp_pkg.sv
`include "fxp_defs.svh"

package fxp_pkg;

    // input sample as it arrives on in_data
    typedef logic signed [`FXP_IN_WIDTH-1:0] sample_t;

    // gain as written through gain_data
    typedef logic signed [`FXP_GAIN_WIDTH-1:0] gain_t;

    // full precision product, nothing dropped
    typedef logic signed [`FXP_PROD_WIDTH-1:0] prod_t;

    // converted result as it leaves on out_data
    typedef logic signed [`FXP_OUT_WIDTH-1:0] out_t;

    // occupancy count, has to reach the depth itself
    // so one bit wider than a pointer
    typedef logic [$clog2(`FXP_FIFO_DEPTH+1)-1:0] fifo_count_t;

endpackage

//--- sample_admit.sv
`timescale 1ns/1ps
`include "fxp_defs.svh"

module sample_admit (
    input  logic                 clk,
    input  logic                 rst,
    input  fxp_pkg::sample_t     in_data,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  fxp_pkg::gain_t       gain_data,
    input  logic                 gain_load,
    input  fxp_pkg::fifo_count_t fifo_count,
    input  logic                 cast_valid,
    output fxp_pkg::sample_t     adm_sample,
    output fxp_pkg::gain_t       adm_gain,
    output logic                 adm_valid
);

    // current gain, applies to samples accepted after the load edge
    fxp_pkg::gain_t gain_reg;

    // samples accepted but not yet written into the queue
    fxp_pkg::fifo_count_t in_flight;

    // queue entries plus pipeline items, one extra bit so the sum never wraps
    logic [$bits(fxp_pkg::fifo_count_t):0] committed;

    logic accept;

    assign committed = fifo_count + in_flight;

    // only take a sample when a queue slot is guaranteed for it
    assign in_ready = committed < `FXP_FIFO_DEPTH;
    assign accept   = in_valid & in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            gain_reg <= `FXP_GAIN_RESET;
        end else if (gain_load) begin
            gain_reg <= gain_data;
        end
    end

    // credit taken on accept, given back when the result lands in the queue
    always_ff @(posedge clk) begin
        if (rst) begin
            in_flight <= '0;
        end else begin
            case ({accept, cast_valid})
                2'b10:   in_flight <= in_flight + 1'b1;
                2'b01:   in_flight <= in_flight - 1'b1;
                default: in_flight <= in_flight;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            adm_valid <= 1'b0;
        end else begin
            adm_valid <= accept;
        end
    end

    // sample and gain travel together, a later load cannot touch this item
    // gain_reg here is still the old value on a same-edge load
    always_ff @(posedge clk) begin
        if (accept) begin
            adm_sample <= in_data;
            adm_gain   <= gain_reg;
        end
    end

    // three register stages between accept and the queue write
    a_in_flight_max: assert property (@(posedge clk) disable iff (rst)
        in_flight <= 3)
        else $error("in_flight above pipeline depth: %0d", in_flight);

    // a result can only land for a sample that took a credit
    a_no_spurious_land: assert property (@(posedge clk) disable iff (rst)
        cast_valid |-> in_flight != 0)
        else $error("cast_valid with no sample in flight");

endmodule

//--- gain_mult.sv
`timescale 1ns/1ps

module gain_mult (
    input  logic             clk,
    input  logic             rst,
    input  fxp_pkg::sample_t adm_sample,
    input  fxp_pkg::gain_t   adm_gain,
    input  logic             adm_valid,
    output fxp_pkg::prod_t   mult_prod,
    output logic             mult_valid
);

    // full precision signed product
    // Q4.12 times Q2.14 gives Q6.26, both operands signed so
    // they sign extend to the 32 bit result width
    always_ff @(posedge clk) begin
        mult_prod <= adm_sample * adm_gain;
    end

    // valid follows the product by the same one stage
    always_ff @(posedge clk) begin
        if (rst) begin
            mult_valid <= 1'b0;
        end else begin
            mult_valid <= adm_valid;
        end
    end

endmodule

//--- signed_cast.sv
`timescale 1ns/1ps

module signed_cast #(
    parameter int din_width  = 32,
    parameter int din_point  = 26,
    parameter int dout_width = 12,
    parameter int dout_point = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [din_width-1:0]  din,
    input  logic                  din_valid,
    output logic [dout_width-1:0] dout,
    output logic                  dout_valid
);

    // integer field widths, sign included
    localparam int din_int  = din_width - din_point;
    localparam int dout_int = dout_width - dout_point;

    logic [dout_int-1:0]   dout_int_q;
    logic [dout_point-1:0] dout_frac_q;

    logic sign;

    assign sign = din[din_width-1];

    // integer part
    generate
        if (din_int == dout_int) begin : g_int_same
            // same width, copy straight across
            always_ff @(posedge clk) begin
                dout_int_q <= din[din_width-1 -: din_int];
            end
        end else if (din_int > dout_int) begin : g_int_narrow
            // bits above the kept field plus the sign, all must match the sign
            localparam int chk = din_int - dout_int + 1;
            always_ff @(posedge clk) begin
                if (!sign && (|din[din_width-1 -: chk])) begin
                    // positive overflow, largest positive integer
                    dout_int_q <= {1'b0, {(dout_int-1){1'b1}}};
                end else if (sign && !(&din[din_width-1 -: chk])) begin
                    // negative overflow, most negative integer
                    dout_int_q <= {1'b1, {(dout_int-1){1'b0}}};
                end else begin
                    // fits, keep sign and the low integer bits
                    if (dout_int == 1) begin
                        dout_int_q <= sign;
                    end else begin
                        dout_int_q <= {sign, din[din_point +: (dout_int > 1 ? dout_int-1 : 1)]};
                    end
                end
            end
        end else begin : g_int_wide
            // no overflow possible, just extend the sign
            always_ff @(posedge clk) begin
                dout_int_q <= {{(dout_int-din_int){sign}}, din[din_point +: din_int]};
            end
        end
    endgenerate

    // fractional part, untouched by saturation
    generate
        if (dout_point <= din_point) begin : g_frac_trunc
            // keep the top fraction bits, the rest is dropped
            always_ff @(posedge clk) begin
                dout_frac_q <= din[din_point-1 -: dout_point];
            end
        end else if (din_point == 0) begin : g_frac_zero
            // no input fraction at all
            always_ff @(posedge clk) begin
                dout_frac_q <= '0;
            end
        end else begin : g_frac_pad
            // zeros fill the low bits
            always_ff @(posedge clk) begin
                dout_frac_q <= {din[din_point-1:0], {(dout_point-din_point){1'b0}}};
            end
        end
    endgenerate

    assign dout = {dout_int_q, dout_frac_q};

    always_ff @(posedge clk) begin
        if (rst) begin
            dout_valid <= 1'b0;
        end else begin
            dout_valid <= din_valid;
        end
    end

    // a valid result comes from a fully known product upstream
    a_dout_known: assert property (@(posedge clk) disable iff (rst)
        dout_valid |-> !$isunknown(dout))
        else $error("unknown bits on a valid cast result");

endmodule

//--- result_fifo.sv
`timescale 1ns/1ps
`include "fxp_defs.svh"

module result_fifo (
    input  logic                 clk,
    input  logic                 rst,
    input  fxp_pkg::out_t        wr_data,
    input  logic                 wr_valid,
    output fxp_pkg::out_t        out_data,
    output logic                 out_valid,
    input  logic                 out_ready,
    output fxp_pkg::fifo_count_t fifo_count
);

    // pointer width for the entry index
    typedef logic [$clog2(`FXP_FIFO_DEPTH)-1:0] ptr_t;

    fxp_pkg::out_t mem [`FXP_FIFO_DEPTH];

    ptr_t wr_ptr;
    ptr_t rd_ptr;

    logic do_write;
    logic do_read;

    // no full check on write, the admit credits keep a slot free
    assign do_write = wr_valid;
    assign do_read  = out_valid & out_ready;

    assign out_valid = fifo_count != 0;
    assign out_data  = mem[rd_ptr];

    // storage, no reset needed
    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // pointers wrap at the last entry
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == ptr_t'(`FXP_FIFO_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == ptr_t'(`FXP_FIFO_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // read and write together leave the count as it is
    always_ff @(posedge clk) begin
        if (rst) begin
            fifo_count <= '0;
        end else begin
            case ({do_write, do_read})
                2'b10:   fifo_count <= fifo_count + 1'b1;
                2'b01:   fifo_count <= fifo_count - 1'b1;
                default: fifo_count <= fifo_count;
            endcase
        end
    end

    // credit scheme upstream must never let a write hit a full queue
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        wr_valid |-> fifo_count != `FXP_FIFO_DEPTH)
        else $error("write into a full result queue");

    a_count_max: assert property (@(posedge clk) disable iff (rst)
        fifo_count <= `FXP_FIFO_DEPTH)
        else $error("queue count above depth: %0d", fifo_count);

endmodule

//--- gain_cast_top.sv
`timescale 1ns/1ps
`include "fxp_defs.svh"

module gain_cast_top (
    input  logic             clk,
    input  logic             rst,
    input  fxp_pkg::sample_t in_data,
    input  logic             in_valid,
    output logic             in_ready,
    input  fxp_pkg::gain_t   gain_data,
    input  logic             gain_load,
    output fxp_pkg::out_t    out_data,
    output logic             out_valid,
    input  logic             out_ready
);

    // admit to multiplier
    fxp_pkg::sample_t adm_sample;
    fxp_pkg::gain_t   adm_gain;
    logic             adm_valid;

    // multiplier to cast
    fxp_pkg::prod_t mult_prod;
    logic           mult_valid;

    // cast to queue, cast_valid also returns the credit
    fxp_pkg::out_t cast_data;
    logic          cast_valid;

    fxp_pkg::fifo_count_t fifo_count;

    sample_admit u_admit (
        .clk        (clk),
        .rst        (rst),
        .in_data    (in_data),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .gain_data  (gain_data),
        .gain_load  (gain_load),
        .fifo_count (fifo_count),
        .cast_valid (cast_valid),
        .adm_sample (adm_sample),
        .adm_gain   (adm_gain),
        .adm_valid  (adm_valid)
    );

    gain_mult u_mult (
        .clk        (clk),
        .rst        (rst),
        .adm_sample (adm_sample),
        .adm_gain   (adm_gain),
        .adm_valid  (adm_valid),
        .mult_prod  (mult_prod),
        .mult_valid (mult_valid)
    );

    // Q6.26 down to Q4.8
    signed_cast #(
        .din_width  (`FXP_PROD_WIDTH),
        .din_point  (`FXP_PROD_POINT),
        .dout_width (`FXP_OUT_WIDTH),
        .dout_point (`FXP_OUT_POINT)
    ) u_cast (
        .clk        (clk),
        .rst        (rst),
        .din        (mult_prod),
        .din_valid  (mult_valid),
        .dout       (cast_data),
        .dout_valid (cast_valid)
    );

    result_fifo u_fifo (
        .clk        (clk),
        .rst        (rst),
        .wr_data    (cast_data),
        .wr_valid   (cast_valid),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .fifo_count (fifo_count)
    );

endmodule

//--- tb_gain_cast.sv
`timescale 1ns/1ps
`include "fxp_defs.svh"

module tb_gain_cast;

    localparam int in_timeout    = 200;
    localparam int drain_timeout = 400;
    localparam int stream_cycles = 600;

    logic             clk;
    logic             rst;
    fxp_pkg::sample_t in_data;
    logic             in_valid;
    logic             in_ready;
    fxp_pkg::gain_t   gain_data;
    logic             gain_load;
    fxp_pkg::out_t    out_data;
    logic             out_valid;
    logic             out_ready;

    integer     seed;
    string      test_name;
    int         i;
    logic       took;
    logic       was_valid;
    logic       hold;
    logic [31:0] rnd;

    // gain the DUT will apply to the next accepted sample
    fxp_pkg::gain_t model_gain;
    fxp_pkg::out_t  exp_q[$];
    fxp_pkg::out_t  exp_head;
    int             exp_count;

    // handshakes seen at the falling edge, booked at the next rising edge
    logic             cap_rst;
    logic             cap_in_fire;
    logic             cap_out_fire;
    logic             cap_load;
    fxp_pkg::sample_t cap_sample;
    fxp_pkg::gain_t   cap_gain;

    // rising edges in a row with out_ready low and in_valid high
    int stall_cycles;

    gain_cast_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .gain_data (gain_data),
        .gain_load (gain_load),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Q4.12 times Q2.14 gives Q6.26, then down to Q4.8
    function automatic fxp_pkg::out_t expected_out(input fxp_pkg::sample_t s,
                                                   input fxp_pkg::gain_t g);
        fxp_pkg::prod_t p;
        logic [3:0]     int_f;
        logic [7:0]     frac_f;
        p      = fxp_pkg::prod_t'(s) * fxp_pkg::prod_t'(g);
        // top 8 fraction bits, rest dropped even when saturated
        frac_f = p[25:18];
        if (p[31:29] == {3{p[31]}}) begin
            int_f = {p[31], p[28:26]};
        end else if (!p[31]) begin
            int_f = 4'b0111;
        end else begin
            int_f = 4'b1000;
        end
        return {int_f, frac_f};
    endfunction

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic report_error(input string why);
        $display("ERROR in %s: %s", test_name, why);
        abort_run();
    endtask

    task automatic report_mismatch(input fxp_pkg::out_t exp_v, input fxp_pkg::out_t act_v);
        $display("FAIL %s expected %h actual %h", test_name, exp_v, act_v);
        abort_run();
    endtask

    // hold the pending sample until it is taken, strobe drops after one edge
    task automatic wait_accept();
        int waited;
        waited = 0;
        @(negedge clk);
        while (in_valid && !in_ready) begin
            if (waited == in_timeout) begin
                report_error("timeout waiting for in_ready");
            end
            waited++;
            @(posedge clk);
            gain_load <= 1'b0;
            @(negedge clk);
        end
        @(posedge clk);
        gain_load <= 1'b0;
        in_valid  <= 1'b0;
    endtask

    // load set means the gain strobe goes out on the same edge as the sample
    task automatic send_sample(input fxp_pkg::sample_t s, input logic load,
                               input fxp_pkg::gain_t g);
        in_data   <= s;
        in_valid  <= 1'b1;
        gain_data <= g;
        gain_load <= load;
        wait_accept();
    endtask

    task automatic load_gain(input fxp_pkg::gain_t g);
        gain_data <= g;
        gain_load <= 1'b1;
        @(posedge clk);
        gain_load <= 1'b0;
    endtask

    // every expected result out and the queue empty
    task automatic wait_drain();
        int waited;
        waited = 0;
        @(negedge clk);
        while (exp_count != 0 || out_valid) begin
            if (waited == drain_timeout) begin
                report_error("timeout waiting for the output queue to drain");
            end
            waited++;
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    always @(negedge clk) begin
        cap_rst      = rst;
        cap_in_fire  = in_valid && in_ready;
        cap_out_fire = out_valid && out_ready;
        cap_load     = gain_load;
        cap_sample   = in_data;
        cap_gain     = gain_data;
    end

    // scoreboard, a same-edge load still leaves the old gain on that sample
    always @(posedge clk) begin
        if (cap_rst) begin
            exp_q.delete();
            model_gain = `FXP_GAIN_RESET;
        end else begin
            if (cap_out_fire && exp_q.size() != 0) begin
                void'(exp_q.pop_front());
            end
            if (cap_in_fire) begin
                exp_q.push_back(expected_out(cap_sample, model_gain));
            end
            if (cap_load) begin
                model_gain = cap_gain;
            end
        end
        exp_count = exp_q.size();
        exp_head  = (exp_count != 0) ? exp_q[0] : '0;
    end

    a_reset_state: assert property (@(negedge clk)
        $fell(rst) |-> (!out_valid && in_ready))
        else report_error("out_valid high or in_ready low right after reset");

    a_out_expected: assert property (@(negedge clk) disable iff (rst)
        (out_valid && out_ready) |-> exp_count != 0)
        else report_error("output handshake with no result expected");

    // oldest expected result against every output handshake
    a_out_match: assert property (@(negedge clk) disable iff (rst)
        (out_valid && out_ready && exp_count != 0) |-> out_data == exp_head)
        else report_mismatch(exp_head, out_data);

    a_out_hold: assert property (@(negedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
        else report_error("out_data changed or dropped while stalled");

    // 8 credits are gone well before 12 stalled edges
    a_stall_backs_up: assert property (@(negedge clk) disable iff (rst)
        stall_cycles >= 12 |-> !in_ready)
        else report_error("in_ready still high during a long output stall");

    initial begin
        seed         = 18278;
        test_name    = "reset";
        rst          = 1'b1;
        in_data      = '0;
        in_valid     = 1'b0;
        gain_data    = '0;
        gain_load    = 1'b0;
        out_ready    = 1'b1;
        stall_cycles = 0;
        cap_rst      = 1'b1;
        cap_in_fire  = 1'b0;
        cap_out_fire = 1'b0;
        cap_load     = 1'b0;
        cap_sample   = '0;
        cap_gain     = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        test_name = "unity_gain";
        send_sample(16'h0000, 1'b0, '0);
        send_sample(16'h1000, 1'b0, '0);
        send_sample(16'h7FFF, 1'b0, '0);
        send_sample(16'h8000, 1'b0, '0);
        send_sample(16'hF800, 1'b0, '0);
        send_sample(16'h1234, 1'b0, '0);
        for (i = 0; i < 10; i++) begin
            send_sample(fxp_pkg::sample_t'($random(seed)), 1'b0, '0);
        end
        wait_drain();

        // gain just under 2.0, products past +8
        test_name = "positive_saturation";
        load_gain(16'h7FFF);
        send_sample(16'h7000, 1'b0, '0);
        send_sample(16'h5000, 1'b0, '0);
        send_sample(16'h4800, 1'b0, '0);
        send_sample(16'h3000, 1'b0, '0);
        wait_drain();

        test_name = "negative_saturation";
        send_sample(16'h9000, 1'b0, '0);
        send_sample(16'hB000, 1'b0, '0);
        load_gain(16'h8000);
        send_sample(16'h5000, 1'b0, '0);
        // -8 times -2 lands on +16, out of range on the positive side
        send_sample(16'h8000, 1'b0, '0);
        wait_drain();

        test_name = "gain_change";
        load_gain(16'h2000);
        send_sample(16'h3000, 1'b0, '0);
        send_sample(16'hD000, 1'b0, '0);
        send_sample(16'h2400, 1'b1, 16'h6000);
        send_sample(16'h2400, 1'b0, '0);
        send_sample(16'hE800, 1'b0, '0);
        wait_drain();

        // random stream, output stalled for 20 cycles out of every 100
        test_name = "backpressure";
        for (i = 0; i < stream_cycles; i++) begin
            @(negedge clk);
            took      = in_valid && in_ready;
            was_valid = in_valid;
            @(posedge clk);
            hold = (i % 100) >= 60 && (i % 100) < 80;
            rnd  = $random(seed);
            if (took || !was_valid) begin
                in_data  <= fxp_pkg::sample_t'($random(seed));
                in_valid <= hold ? 1'b1 : (rnd[1:0] != 2'b00);
            end
            gain_load    <= (rnd[6:2] == 5'd0);
            gain_data    <= fxp_pkg::gain_t'($random(seed));
            out_ready    <= hold ? 1'b0 : rnd[8];
            stall_cycles = hold ? stall_cycles + 1 : 0;
        end
        out_ready    <= 1'b1;
        gain_load    <= 1'b0;
        stall_cycles = 0;
        wait_accept();
        wait_drain();

        test_name = "end";
        if (exp_count != 0 || out_valid) begin
            report_error("results left in the queue at the end");
        end else begin
            $display("*** TEST PASSED ***");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+.
fxp_pkg.sv
sample_admit.sv
gain_mult.sv
signed_cast.sv
result_fifo.sv
gain_cast_top.sv
tb_gain_cast.sv

//--- run.sh
#!/bin/sh
# build and run the gain stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_gain_cast -f tb.f -o sim_gain_cast

# the simulator exits non-zero on a fatal check, the log decides
./obj_dir/sim_gain_cast > sim.log 2>&1 || true
cat sim.log

if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
exit 0
